// File: hdl/conv_shape_pkg.sv
package conv_shape_pkg;

    // ========================================
    // channel counts
    // ========================================

    // input channels carried by one tap
    parameter int CONV_CI = 3;

    // output channels, one mac each
    parameter int CONV_CO = 4;

    // ========================================
    // kernel window
    // ========================================

    // taps arrive row-major over the window
    parameter int CONV_KX = 3;
    parameter int CONV_KY = 3;

    // ========================================
    // frame size in output points
    // ========================================

    // points per output row
    parameter int CONV_COL = 4;

    // rows per frame
    parameter int CONV_ROW = 4;

endpackage

// File: hdl/conv_width_pkg.sv
package conv_width_pkg;

    // ========================================
    // operand widths
    // ========================================

    // signed input sample
    parameter int IN_BW = 8;

    // signed kernel weight
    parameter int W_BW = 8;

    // signed per-channel bias
    parameter int B_BW = 16;

    // ========================================
    // derived widths
    // ========================================

    // one signed product
    parameter int PROD_BW = IN_BW + W_BW;

    // headroom for ci * kx * ky = 27 terms, ceil(log2(27))
    parameter int GROWTH_BW = 5;

    // signed accumulator of a whole window
    parameter int ACC_BW = PROD_BW + GROWTH_BW;

    // accumulator plus bias, one extra bit
    parameter int AB_BW = ACC_BW + 1;

    // relu output, sign bit dropped
    parameter int OUT_BW = AB_BW - 1;

endpackage

// File: hdl/tap_counter.sv
`timescale 1ns/100ps

module tap_counter #(
    parameter int N_TAPS   = conv_shape_pkg::CONV_KX * conv_shape_pkg::CONV_KY,
    parameter int N_POINTS = conv_shape_pkg::CONV_COL * conv_shape_pkg::CONV_ROW
) (
    input  logic                      clk,
    input  logic                      reset_n,
    // restart of a frame
    input  logic                      i_clear,
    // one accepted tap
    input  logic                      i_step,
    output logic [$clog2(N_TAPS)-1:0] o_tap_index,
    output logic                      o_last_tap,
    output logic                      o_last_point
);

    localparam int TAP_W   = $clog2(N_TAPS);
    localparam int POINT_W = $clog2(N_POINTS);

    // position inside the kernel window
    logic [TAP_W-1:0]   r_tap_index;
    // output point inside the frame
    logic [POINT_W-1:0] r_point_index;

    // ========================================
    // tap and point counters
    // ========================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_tap_index   <= '0;
            r_point_index <= '0;
        end else if (i_clear) begin
            // clear wins over a step in the same cycle
            r_tap_index   <= '0;
            r_point_index <= '0;
        end else if (i_step) begin
            if (o_last_tap) begin
                // window done, move to next point
                r_tap_index <= '0;
                if (o_last_point) begin
                    r_point_index <= '0;
                end else begin
                    r_point_index <= r_point_index + 1'b1;
                end
            end else begin
                r_tap_index <= r_tap_index + 1'b1;
            end
        end
    end

    // flags straight from the count registers
    assign o_tap_index  = r_tap_index;
    assign o_last_tap   = (r_tap_index == TAP_W'(N_TAPS - 1));
    assign o_last_point = (r_point_index == POINT_W'(N_POINTS - 1));

endmodule

// File: hdl/conv_ctrl_fsm.sv
`timescale 1ns/100ps

module conv_ctrl_fsm (
    input  logic clk,
    input  logic reset_n,
    // frame start pulse
    input  logic i_start,
    // tap strobe from upstream
    input  logic i_in_valid,
    // count flags from tap_counter
    input  logic i_last_tap,
    input  logic i_last_point,
    // result strobe out of the relu pipe
    input  logic i_ot_valid,
    output logic o_tap_accept,
    output logic o_busy,
    output logic o_done
);

    // ========================================
    // state encoding
    // ========================================

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        DRAIN = 2'd2
    } state_t;

    state_t r_state;
    state_t w_next_state;
    logic   r_done;

    // ========================================
    // next state
    // ========================================

    always_comb begin
        w_next_state = r_state;
        case (r_state)
            IDLE: begin
                // start while busy never reaches here
                if (i_start) begin
                    w_next_state = RUN;
                end
            end
            RUN: begin
                // final tap of the final point taken
                if (o_tap_accept && i_last_tap && i_last_point) begin
                    w_next_state = DRAIN;
                end
            end
            DRAIN: begin
                // wait for the last result to leave the pipe
                if (i_ot_valid) begin
                    w_next_state = IDLE;
                end
            end
            default: begin
                w_next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_state <= IDLE;
            r_done  <= 1'b0;
        end else begin
            r_state <= w_next_state;
            // one cycle after the last result
            r_done  <= (r_state == DRAIN) && i_ot_valid;
        end
    end

    // taps count only while running
    assign o_tap_accept = i_in_valid && (r_state == RUN);
    assign o_busy       = (r_state != IDLE);
    assign o_done       = r_done;

endmodule

// File: hdl/channel_mac.sv
`timescale 1ns/100ps

module channel_mac #(
    parameter int CI     = conv_shape_pkg::CONV_CI,
    parameter int N_TAPS = conv_shape_pkg::CONV_KX * conv_shape_pkg::CONV_KY
) (
    input  logic                                            clk,
    input  logic                                            reset_n,
    // accepted tap
    input  logic                                            i_tap_valid,
    input  logic [$clog2(N_TAPS)-1:0]                       i_tap_index,
    input  logic                                            i_last_tap,
    // ci samples of the current tap
    input  logic signed [CI*conv_width_pkg::IN_BW-1:0]      i_in_fmap,
    // ci major, then tap
    input  logic signed [CI*N_TAPS*conv_width_pkg::W_BW-1:0] i_weight,
    output logic                                            o_acc_valid,
    output logic signed [conv_width_pkg::ACC_BW-1:0]        o_acc
);

    localparam int IN_BW   = conv_width_pkg::IN_BW;
    localparam int W_BW    = conv_width_pkg::W_BW;
    localparam int PROD_BW = conv_width_pkg::PROD_BW;
    localparam int ACC_BW  = conv_width_pkg::ACC_BW;

    // one product per input channel
    logic signed [PROD_BW-1:0] w_prod [CI];
    // sum over input channels for this tap
    logic signed [ACC_BW-1:0]  w_tap_sum;

    logic signed [ACC_BW-1:0]  r_acc;
    logic                      r_acc_valid;

    // ========================================
    // products of the current tap
    // ========================================

    always_comb begin
        for (int c = 0; c < CI; c++) begin
            // weight of channel c at this tap
            w_prod[c] = $signed(i_in_fmap[c*IN_BW +: IN_BW])
                      * $signed(i_weight[(c*N_TAPS + i_tap_index)*W_BW +: W_BW]);
        end
    end

    // sign extended into accumulator width
    always_comb begin
        w_tap_sum = '0;
        for (int c = 0; c < CI; c++) begin
            w_tap_sum = w_tap_sum + w_prod[c];
        end
    end

    // ========================================
    // accumulator
    // ========================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_acc       <= '0;
            r_acc_valid <= 1'b0;
        end else begin
            // pulse for one cycle after the last tap
            r_acc_valid <= i_tap_valid && i_last_tap;
            if (i_tap_valid) begin
                if (i_tap_index == '0) begin
                    // first tap of a new point, drop the old sum
                    r_acc <= w_tap_sum;
                end else begin
                    r_acc <= r_acc + w_tap_sum;
                end
            end
        end
    end

    // finished sum holds until the next first tap
    assign o_acc_valid = r_acc_valid;
    assign o_acc       = r_acc;

endmodule

// File: hdl/bias_relu_stage.sv
`timescale 1ns/100ps

module bias_relu_stage #(
    parameter int CO = conv_shape_pkg::CONV_CO
) (
    input  logic                                      clk,
    input  logic                                      reset_n,
    // all channel sums finished
    input  logic                                      i_acc_valid,
    input  logic signed [CO*conv_width_pkg::ACC_BW-1:0] i_acc,
    input  logic signed [CO*conv_width_pkg::B_BW-1:0]   i_bias,
    output logic                                      o_ot_valid,
    output logic [CO*conv_width_pkg::OUT_BW-1:0]      o_ot_fmap
);

    localparam int ACC_BW = conv_width_pkg::ACC_BW;
    localparam int B_BW   = conv_width_pkg::B_BW;
    localparam int AB_BW  = conv_width_pkg::AB_BW;
    localparam int OUT_BW = conv_width_pkg::OUT_BW;

    // bit 0 marks bias stage, bit 1 marks relu stage
    logic [1:0] r_valid;

    // ========================================
    // valid shift register
    // ========================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid <= '0;
        end else begin
            r_valid[0] <= i_acc_valid;
            r_valid[1] <= r_valid[0];
        end
    end

    // ========================================
    // per channel bias add and relu
    // ========================================

    for (genvar c = 0; c < CO; c++) begin : gen_ch
        logic signed [ACC_BW-1:0] w_acc;
        logic signed [B_BW-1:0]   w_bias;
        logic signed [AB_BW-1:0]  r_add_bias;
        logic [OUT_BW-1:0]        w_relu;
        logic [OUT_BW-1:0]        r_relu;

        assign w_acc  = i_acc[c*ACC_BW +: ACC_BW];
        assign w_bias = i_bias[c*B_BW +: B_BW];

        // stage one, both operands sign extended to ab width
        always_ff @(posedge clk or negedge reset_n) begin
            if (!reset_n) begin
                r_add_bias <= '0;
            end else if (i_acc_valid) begin
                r_add_bias <= w_acc + w_bias;
            end
        end

        // negative clamps to zero, sign bit dropped
        assign w_relu = r_add_bias[AB_BW-1] ? '0 : r_add_bias[OUT_BW-1:0];

        // stage two
        always_ff @(posedge clk or negedge reset_n) begin
            if (!reset_n) begin
                r_relu <= '0;
            end else if (r_valid[0]) begin
                r_relu <= w_relu;
            end
        end

        assign o_ot_fmap[c*OUT_BW +: OUT_BW] = r_relu;
    end

    assign o_ot_valid = r_valid[1];

endmodule

// File: hdl/conv_core.sv
`timescale 1ns/100ps

module conv_core #(
    parameter int CI  = conv_shape_pkg::CONV_CI,
    parameter int CO  = conv_shape_pkg::CONV_CO,
    parameter int KX  = conv_shape_pkg::CONV_KX,
    parameter int KY  = conv_shape_pkg::CONV_KY,
    parameter int COL = conv_shape_pkg::CONV_COL,
    parameter int ROW = conv_shape_pkg::CONV_ROW
) (
    input  logic                                             clk,
    input  logic                                             reset_n,
    input  logic                                             i_start,
    input  logic                                             i_in_valid,
    input  logic signed [CI*conv_width_pkg::IN_BW-1:0]       i_in_fmap,
    // co major, then ci, then tap
    input  logic signed [CO*CI*KX*KY*conv_width_pkg::W_BW-1:0] i_cnn_weight,
    input  logic signed [CO*conv_width_pkg::B_BW-1:0]        i_cnn_bias,
    output logic                                             o_ot_valid,
    output logic [CO*conv_width_pkg::OUT_BW-1:0]             o_ot_fmap,
    output logic                                             o_busy,
    output logic                                             o_done
);

    localparam int N_TAPS   = KX * KY;
    localparam int N_POINTS = COL * ROW;
    localparam int TAP_W    = $clog2(N_TAPS);
    // weights owned by one output channel
    localparam int CH_W_BW  = CI * N_TAPS * conv_width_pkg::W_BW;
    localparam int ACC_BW   = conv_width_pkg::ACC_BW;

    logic                    w_tap_accept;
    logic                    w_frame_clear;
    logic [TAP_W-1:0]        w_tap_index;
    logic                    w_last_tap;
    logic                    w_last_point;
    logic [CO-1:0]           w_acc_valid;
    logic                    w_acc_all_valid;
    logic signed [CO*ACC_BW-1:0] w_acc;

    // ========================================
    // control
    // ========================================

    // a start during a frame must not reset the count
    assign w_frame_clear = i_start && !o_busy;

    tap_counter #(
        .N_TAPS   (N_TAPS),
        .N_POINTS (N_POINTS)
    ) u_tap_counter (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_clear      (w_frame_clear),
        .i_step       (w_tap_accept),
        .o_tap_index  (w_tap_index),
        .o_last_tap   (w_last_tap),
        .o_last_point (w_last_point)
    );

    conv_ctrl_fsm u_conv_ctrl_fsm (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_start      (i_start),
        .i_in_valid   (i_in_valid),
        .i_last_tap   (w_last_tap),
        .i_last_point (w_last_point),
        .i_ot_valid   (o_ot_valid),
        .o_tap_accept (w_tap_accept),
        .o_busy       (o_busy),
        .o_done       (o_done)
    );

    // ========================================
    // one mac per output channel
    // ========================================

    for (genvar co = 0; co < CO; co++) begin : gen_mac
        channel_mac #(
            .CI     (CI),
            .N_TAPS (N_TAPS)
        ) u_channel_mac (
            .clk         (clk),
            .reset_n     (reset_n),
            .i_tap_valid (w_tap_accept),
            .i_tap_index (w_tap_index),
            .i_last_tap  (w_last_tap),
            .i_in_fmap   (i_in_fmap),
            .i_weight    (i_cnn_weight[co*CH_W_BW +: CH_W_BW]),
            .o_acc_valid (w_acc_valid[co]),
            .o_acc       (w_acc[co*ACC_BW +: ACC_BW])
        );
    end

    // every mac raises its valid on the same edge
    assign w_acc_all_valid = &w_acc_valid;

    // ========================================
    // bias and activation
    // ========================================

    bias_relu_stage #(
        .CO (CO)
    ) u_bias_relu_stage (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_acc_valid (w_acc_all_valid),
        .i_acc       (w_acc),
        .i_bias      (i_cnn_bias),
        .o_ot_valid  (o_ot_valid),
        .o_ot_fmap   (o_ot_fmap)
    );

endmodule

// File: testbench/conv_core_assertions.sv
`timescale 1ns/100ps

module conv_core_assertions (
    input logic clk,
    input logic reset_n,
    input logic i_ot_valid,
    input logic i_busy,
    input logic i_done
);

    // ========================================
    // control output properties
    // ========================================

    // done closes a frame that was running
    a_done_after_busy: assert property (@(posedge clk) disable iff (!reset_n)
        i_done |-> $past(i_busy))
        else $error("o_done raised without o_busy on the cycle before");

    // results only inside a frame
    a_valid_in_frame: assert property (@(posedge clk) disable iff (!reset_n)
        i_ot_valid |-> i_busy)
        else $error("o_ot_valid raised while o_busy is low");

    // done one cycle behind the last result
    a_done_after_valid: assert property (@(posedge clk) disable iff (!reset_n)
        i_done |-> $past(i_ot_valid))
        else $error("o_done not preceded by o_ot_valid");

endmodule

bind conv_core conv_core_assertions u_conv_core_assertions (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_ot_valid (o_ot_valid),
    .i_busy     (o_busy),
    .i_done     (o_done)
);

// File: testbench/conv_core_tb.sv
`timescale 1ns/100ps

module conv_core_tb;

    localparam int CI       = conv_shape_pkg::CONV_CI;
    localparam int CO       = conv_shape_pkg::CONV_CO;
    localparam int N_TAPS   = conv_shape_pkg::CONV_KX * conv_shape_pkg::CONV_KY;
    localparam int N_POINTS = conv_shape_pkg::CONV_COL * conv_shape_pkg::CONV_ROW;
    localparam int IN_BW    = conv_width_pkg::IN_BW;
    localparam int W_BW     = conv_width_pkg::W_BW;
    localparam int B_BW     = conv_width_pkg::B_BW;
    localparam int OUT_BW   = conv_width_pkg::OUT_BW;
    localparam int FMAP_BW  = CO * OUT_BW;
    // six frames, at most three cycles per tap when gaps are inserted
    localparam int TIMEOUT_CYCLES = 6 * N_POINTS * N_TAPS * 3 + 500;

    logic                                clk;
    logic                                reset_n;
    logic                                i_start;
    logic                                i_in_valid;
    logic signed [CI*IN_BW-1:0]          i_in_fmap;
    logic signed [CO*CI*N_TAPS*W_BW-1:0] i_cnn_weight;
    logic signed [CO*B_BW-1:0]           i_cnn_bias;
    logic                                o_ot_valid;
    logic [FMAP_BW-1:0]                  o_ot_fmap;
    logic                                o_busy;
    logic                                o_done;

    int seed             = 92;
    int cycle_cnt        = 0;
    int valid_count      = 0;
    int done_count       = 0;
    int last_valid_cycle = 0;

    // model data of the current frame
    int in_arr [N_POINTS*N_TAPS][CI];
    int w_arr  [CO][CI][N_TAPS];
    int b_arr  [CO];
    // expected results and the cycle each one must show up in
    logic [FMAP_BW-1:0] exp_q [$];
    int                 exp_cycle_q [$];

    conv_core #(
        .CI  (CI),
        .CO  (CO),
        .KX  (conv_shape_pkg::CONV_KX),
        .KY  (conv_shape_pkg::CONV_KY),
        .COL (conv_shape_pkg::CONV_COL),
        .ROW (conv_shape_pkg::CONV_ROW)
    ) i_conv_core (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_start      (i_start),
        .i_in_valid   (i_in_valid),
        .i_in_fmap    (i_in_fmap),
        .i_cnn_weight (i_cnn_weight),
        .i_cnn_bias   (i_cnn_bias),
        .o_ot_valid   (o_ot_valid),
        .o_ot_fmap    (o_ot_fmap),
        .o_busy       (o_busy),
        .o_done       (o_done)
    );

    // ========================================
    // clock, cycle count, error exits
    // ========================================

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_problem("run exceeded its cycle limit without finishing");
        end
    end

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [FMAP_BW-1:0] exp_v,
                                   input logic [FMAP_BW-1:0] act_v);
        $display("[FAIL] %s expected %h actual %h", name, exp_v, act_v);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        abort_run();
    endtask

    // ========================================
    // output monitor, sampled mid cycle
    // ========================================

    always @(negedge clk) begin
        if (reset_n && o_ot_valid) begin
            assert (exp_q.size() > 0)
                else report_problem("output point arrived while none was expected");
            assert (o_ot_fmap == exp_q[0])
                else report_mismatch("o_ot_fmap", exp_q[0], o_ot_fmap);
            // three edges after the last tap of the point
            assert (cycle_cnt == exp_cycle_q[0])
                else report_mismatch("o_ot_valid cycle", FMAP_BW'(exp_cycle_q[0]),
                                     FMAP_BW'(cycle_cnt));
            void'(exp_q.pop_front());
            void'(exp_cycle_q.pop_front());
            valid_count++;
            last_valid_cycle = cycle_cnt;
        end
        if (reset_n && o_done) begin
            assert (cycle_cnt == last_valid_cycle + 1)
                else report_mismatch("o_done cycle", FMAP_BW'(last_valid_cycle + 1),
                                     FMAP_BW'(cycle_cnt));
            assert (!o_busy)
                else report_problem("o_busy still high in the o_done cycle");
            done_count++;
        end
    end

    // ========================================
    // stimulus and reference model
    // ========================================

    task automatic drive_step();
        @(posedge clk);
        #0.5;
    endtask

    function automatic int rand_range(input int lo, input int hi);
        rand_range = lo + int'({$random(seed)} % (hi - lo + 1));
    endfunction

    // fresh inputs, weights and biases, weights ordered co, then ci, then tap
    task automatic load_random_data(input int in_lo, input int in_hi, input int w_lo,
                                    input int w_hi, input int b_lo, input int b_hi);
        for (int n = 0; n < N_POINTS * N_TAPS; n++) begin
            for (int c = 0; c < CI; c++) begin
                in_arr[n][c] = rand_range(in_lo, in_hi);
            end
        end
        for (int co = 0; co < CO; co++) begin
            b_arr[co] = rand_range(b_lo, b_hi);
            i_cnn_bias[co*B_BW +: B_BW] = B_BW'(b_arr[co]);
            for (int c = 0; c < CI; c++) begin
                for (int t = 0; t < N_TAPS; t++) begin
                    w_arr[co][c][t] = rand_range(w_lo, w_hi);
                    i_cnn_weight[((co*CI + c)*N_TAPS + t)*W_BW +: W_BW] =
                        W_BW'(w_arr[co][c][t]);
                end
            end
        end
    endtask

    // sum of products plus bias, relu, low out_bw bits
    task automatic build_expected();
        int                 sum;
        logic [FMAP_BW-1:0] exp_fmap;
        for (int p = 0; p < N_POINTS; p++) begin
            for (int co = 0; co < CO; co++) begin
                sum = b_arr[co];
                for (int t = 0; t < N_TAPS; t++) begin
                    for (int c = 0; c < CI; c++) begin
                        sum += in_arr[p*N_TAPS + t][c] * w_arr[co][c][t];
                    end
                end
                if (sum < 0) begin
                    sum = 0;
                end
                exp_fmap[co*OUT_BW +: OUT_BW] = OUT_BW'(sum);
            end
            exp_q.push_back(exp_fmap);
        end
    endtask

    // one frame, optional idle gaps and a start pulse in the middle
    task automatic run_frame(input bit with_gaps, input bit mid_start);
        int start_done;
        int start_valids;
        int idle;
        start_done   = done_count;
        start_valids = valid_count;
        build_expected();
        i_start = 1'b1;
        drive_step();
        assert (o_busy) else report_mismatch("o_busy", 1, FMAP_BW'(o_busy));
        for (int n = 0; n < N_POINTS * N_TAPS; n++) begin
            if (with_gaps) begin
                idle       = rand_range(0, 2);
                i_start    = 1'b0;
                i_in_valid = 1'b0;
                repeat (idle) drive_step();
            end
            i_in_valid = 1'b1;
            i_start    = mid_start && (n == 40);
            for (int c = 0; c < CI; c++) begin
                i_in_fmap[c*IN_BW +: IN_BW] = IN_BW'(in_arr[n][c]);
            end
            // tap is taken on the coming edge
            if (n % N_TAPS == N_TAPS - 1) begin
                exp_cycle_q.push_back(cycle_cnt + 3);
            end
            drive_step();
        end
        i_in_valid = 1'b0;
        i_start    = 1'b0;
        while (done_count == start_done) begin
            drive_step();
        end
        assert (valid_count - start_valids == N_POINTS)
            else report_mismatch("o_ot_valid count", FMAP_BW'(N_POINTS),
                                 FMAP_BW'(valid_count - start_valids));
    endtask

    // taps while idle must be dropped
    task automatic drive_stray_taps(input int count);
        for (int n = 0; n < count; n++) begin
            i_in_valid = 1'b1;
            i_in_fmap  = (CI*IN_BW)'($random(seed));
            drive_step();
        end
        i_in_valid = 1'b0;
        repeat (8) drive_step();
    endtask

    // ========================================
    // directed tests
    // ========================================

    task automatic test_reset();
        @(negedge clk);
        assert (!o_ot_valid) else report_mismatch("o_ot_valid", '0, FMAP_BW'(o_ot_valid));
        assert (!o_done) else report_mismatch("o_done", '0, FMAP_BW'(o_done));
        assert (!o_busy) else report_mismatch("o_busy", '0, FMAP_BW'(o_busy));
        assert (o_ot_fmap == '0) else report_mismatch("o_ot_fmap", '0, o_ot_fmap);
        drive_step();
    endtask

    task automatic test_full_frame();
        load_random_data(-128, 127, -128, 127, -32768, 32767);
        run_frame(1'b0, 1'b0);
    endtask

    // same data as the previous frame
    task automatic test_gaps();
        run_frame(1'b1, 1'b0);
    endtask

    task automatic test_relu();
        // every sum negative
        load_random_data(0, 127, -128, -1, -32768, -1);
        run_frame(1'b0, 1'b0);
        load_random_data(-128, 127, -128, 127, 0, 32767);
        run_frame(1'b0, 1'b0);
    endtask

    task automatic test_latency_done();
        load_random_data(-128, 127, -128, 127, -32768, 32767);
        run_frame(1'b1, 1'b0);
        assert (!o_busy) else report_mismatch("o_busy", '0, FMAP_BW'(o_busy));
    endtask

    task automatic test_ignored_taps();
        drive_stray_taps(12);
        load_random_data(-128, 127, -128, 127, -32768, 32767);
        run_frame(1'b0, 1'b1);
        drive_stray_taps(12);
    endtask

    initial begin
        reset_n      = 1'b0;
        i_start      = 1'b0;
        i_in_valid   = 1'b0;
        i_in_fmap    = '0;
        i_cnn_weight = '0;
        i_cnn_bias   = '0;
        repeat (16) @(posedge clk);
        #0.5;
        reset_n = 1'b1;
        test_reset();
        test_full_frame();
        test_gaps();
        test_relu();
        test_latency_done();
        test_ignored_taps();
        $display("all tests passed");
        $finish;
    end

endmodule

// File: project.f
hdl/conv_shape_pkg.sv
hdl/conv_width_pkg.sv
hdl/tap_counter.sv
hdl/conv_ctrl_fsm.sv
hdl/channel_mac.sv
hdl/bias_relu_stage.sv
hdl/conv_core.sv
testbench/conv_core_assertions.sv
testbench/conv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the conv_core testbench with verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module conv_core_tb -o conv_core_sim

./obj_dir/conv_core_sim | tee "$LOG"

if grep -q "tests failed" "$LOG"; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "all tests passed" "$LOG"; then
    echo "simulation ended without a pass report"
    exit 1
fi
echo "simulation PASSED"
